// File: hw/isa_pkg.sv
package isa_pkg;

  localparam int unsigned INSN_WIDTH = 32;
  localparam int unsigned GPR_IDX_WIDTH = 5;
  localparam int unsigned IMM_WIDTH = 64;

  // Kept A64 instructions, everything else decodes to OP_ERR.
  typedef enum logic [4:0] {
    OP_LDUR,
    OP_STUR,
    OP_MOVZ,
    OP_MOVK,
    OP_ADR,
    OP_ADRP,
    OP_ADD,
    OP_SUB,
    OP_ADDS,
    OP_SUBS,
    OP_ORR,
    OP_ORN,
    OP_EOR,
    OP_ANDS,
    OP_CSEL,
    OP_CSINC,
    OP_CSINV,
    OP_CSNEG,
    OP_B,
    OP_B_COND,
    OP_BL,
    OP_BR,
    OP_BLR,
    OP_RET,
    OP_CBZ,
    OP_CBNZ,
    OP_NOP,
    OP_HLT,
    OP_ERR
  } opcode_t;

  // Values follow the architectural cond encoding.
  typedef enum logic [3:0] {
    COND_EQ = 4'h0,
    COND_NE = 4'h1,
    COND_CS = 4'h2,
    COND_CC = 4'h3,
    COND_MI = 4'h4,
    COND_PL = 4'h5,
    COND_VS = 4'h6,
    COND_VC = 4'h7,
    COND_HI = 4'h8,
    COND_LS = 4'h9,
    COND_GE = 4'ha,
    COND_LT = 4'hb,
    COND_GT = 4'hc,
    COND_LE = 4'hd,
    COND_AL = 4'he,
    COND_NV = 4'hf
  } cond_t;

  // One instruction word, seen either as a data-processing or load/store
  // format or as a branch / PC-relative format.
  typedef union packed {
    struct packed {
      logic [9:0] op;
      // Bits [21:5] hold different fields per format.
      union packed {
        struct packed {
          logic [11:0] imm12;
          logic [GPR_IDX_WIDTH-1:0] rn;
        } arith;
        struct packed {
          logic b21;
          logic [GPR_IDX_WIDTH-1:0] rm;
          logic [3:0] cond;
          logic [1:0] op2;
          logic [GPR_IDX_WIDTH-1:0] rn;
        } rrr;
        struct packed {
          logic b21;
          logic [8:0] imm9;
          logic [1:0] op2;
          logic [GPR_IDX_WIDTH-1:0] rn;
        } mem;
        struct packed {
          logic b21;
          logic [15:0] hw16;
        } mov;
      } f;
      logic [GPR_IDX_WIDTH-1:0] rd;
    } dp;
    struct packed {
      logic op31;
      logic [1:0] immlo;
      logic [2:0] op28;
      // Bits [25:0] hold the offset fields.
      union packed {
        logic [25:0] imm26;
        struct packed {
          logic [1:0] op;
          logic [18:0] imm19;
          logic o4;
          logic [3:0] cond;
        } cb;
        struct packed {
          logic [1:0] op;
          logic [18:0] immhi;
          logic [GPR_IDX_WIDTH-1:0] rd;
        } adr;
      } f;
    } br;
  } insn_u;

endpackage

// File: hw/uop_pkg.sv
package uop_pkg;

  import isa_pkg::*;

  // Functional unit that executes the micro-op.
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_LS  = 1'b1
  } fu_t;

  // Operation inside the selected unit.
  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_OR,
    FU_OP_ORN,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_MOV,
    FU_OP_CSEL,
    FU_OP_CSINC,
    FU_OP_CSINV,
    FU_OP_CSNEG,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_ADRX,
    FU_OP_B_COND,
    FU_OP_PASS_A
  } fu_op_t;

  // How a register slot of the micro-op is to be read.
  typedef enum logic [2:0] {
    REG_IS_UNUSED,
    REG_IS_USED,
    REG_IS_PC,
    REG_IS_IMM,
    REG_IS_STUR
  } reg_status_t;

  localparam logic [GPR_IDX_WIDTH-1:0] LINK_REG = 30;
  localparam logic [GPR_IDX_WIDTH-1:0] ZERO_REG = 31;

endpackage

// File: hw/uop_if.sv
`timescale 1ns/1ps

interface uop_if
  import isa_pkg::*, uop_pkg::*;
#(
  parameter int PC_WIDTH = 64
) (
  input logic clk
);

  insn_u insn;
  logic [PC_WIDTH-1:0] pc;
  opcode_t opcode;

  logic [GPR_IDX_WIDTH-1:0] src1;
  logic [GPR_IDX_WIDTH-1:0] src2;
  logic [GPR_IDX_WIDTH-1:0] dst;
  reg_status_t src1_status;
  reg_status_t src2_status;
  reg_status_t dst_status;
  logic [IMM_WIDTH-1:0] imm;
  cond_t cond;

  fu_t fu_id;
  fu_op_t fu_op;
  logic sets_nzcv;
  logic uses_nzcv;

  modport top (
    output insn, pc,
    input opcode, src1, src2, dst, src1_status, src2_status, dst_status,
    input imm, cond, fu_id, fu_op, sets_nzcv, uses_nzcv
  );

  modport decoder (input clk, insn, output opcode);

  modport operands (
    input clk, insn, opcode,
    output src1, src2, dst, src1_status, src2_status, dst_status, imm, cond
  );

  modport control (input opcode, output fu_id, fu_op, sets_nzcv, uses_nzcv);

endinterface

// File: hw/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder
  import isa_pkg::*;
(
  uop_if.decoder u
);

  always_comb begin
    casez (u.insn)
      // Unscaled 64-bit load and store.
      32'b1111_1000_010?_????_????_00??_????_????: u.opcode = OP_LDUR;
      32'b1111_1000_000?_????_????_00??_????_????: u.opcode = OP_STUR;
      // Wide moves, 64-bit.
      32'b1101_0010_1???_????_????_????_????_????: u.opcode = OP_MOVZ;
      32'b1111_0010_1???_????_????_????_????_????: u.opcode = OP_MOVK;
      // PC-relative address, bit 31 picks the page form.
      32'b0??1_0000_????_????_????_????_????_????: u.opcode = OP_ADR;
      32'b1??1_0000_????_????_????_????_????_????: u.opcode = OP_ADRP;
      // Add and subtract immediate.
      32'b1001_0001_0???_????_????_????_????_????: u.opcode = OP_ADD;
      32'b1101_0001_0???_????_????_????_????_????: u.opcode = OP_SUB;
      // Flag-setting add and subtract, shifted register.
      32'b1010_1011_000?_????_????_????_????_????: u.opcode = OP_ADDS;
      32'b1110_1011_000?_????_????_????_????_????: u.opcode = OP_SUBS;
      // Logical, shifted register. Bit 21 is the invert bit.
      32'b1010_1010_000?_????_????_????_????_????: u.opcode = OP_ORR;
      32'b1010_1010_001?_????_????_????_????_????: u.opcode = OP_ORN;
      32'b1100_1010_000?_????_????_????_????_????: u.opcode = OP_EOR;
      32'b1110_1010_000?_????_????_????_????_????: u.opcode = OP_ANDS;
      // Conditional select family.
      32'b1001_1010_100?_????_????_00??_????_????: u.opcode = OP_CSEL;
      32'b1001_1010_100?_????_????_01??_????_????: u.opcode = OP_CSINC;
      32'b1101_1010_100?_????_????_00??_????_????: u.opcode = OP_CSINV;
      32'b1101_1010_100?_????_????_01??_????_????: u.opcode = OP_CSNEG;
      // Immediate branches.
      32'b0001_01??_????_????_????_????_????_????: u.opcode = OP_B;
      32'b0101_0100_????_????_????_????_???0_????: u.opcode = OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: u.opcode = OP_BL;
      // Register branches
      32'b1101_0110_0001_1111_0000_00??_???0_0000: u.opcode = OP_BR;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: u.opcode = OP_BLR;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: u.opcode = OP_RET;
      // Compare and branch, 64-bit.
      32'b1011_0100_????_????_????_????_????_????: u.opcode = OP_CBZ;
      32'b1011_0101_????_????_????_????_????_????: u.opcode = OP_CBNZ;
      // Hint and halt.
      32'b1101_0101_0000_0011_0010_0000_0001_1111: u.opcode = OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: u.opcode = OP_HLT;
      default: u.opcode = OP_ERR;
    endcase
  end

  // A known word must always land on some table entry or on OP_ERR.
  a_opcode_known: assert property (
    @(posedge u.clk) !$isunknown(u.insn) |-> !$isunknown(u.opcode)
  ) else $error("opcode unknown for a known instruction word");

endmodule

// File: hw/operand_extractor.sv
`timescale 1ns/1ps

module operand_extractor
  import isa_pkg::*, uop_pkg::*;
(
  uop_if.operands u
);

  // Destination register.
  always_comb begin
    case (u.opcode)
      OP_B, OP_BR, OP_B_COND, OP_CBZ, OP_CBNZ, OP_RET, OP_NOP, OP_HLT, OP_ERR: begin
        u.dst = ZERO_REG;
        u.dst_status = REG_IS_UNUSED;
      end
      OP_STUR: begin
        u.dst = ZERO_REG;
        u.dst_status = REG_IS_STUR;
      end
      OP_BL, OP_BLR: begin
        u.dst = LINK_REG;
        u.dst_status = REG_IS_USED;
      end
      default: begin
        u.dst = u.insn.dp.rd;
        u.dst_status = REG_IS_USED;
      end
    endcase
  end

  // First source.
  always_comb begin
    case (u.opcode)
      OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP, OP_B, OP_BL, OP_NOP, OP_HLT, OP_ERR: begin
        u.src1 = ZERO_REG;
        u.src1_status = REG_IS_UNUSED;
      end
      OP_B_COND: begin
        u.src1 = ZERO_REG;
        u.src1_status = REG_IS_PC;
      end
      // Rt sits in the rd position for compare and branch.
      OP_CBZ, OP_CBNZ: begin
        u.src1 = u.insn.dp.rd;
        u.src1_status = REG_IS_USED;
      end
      default: begin
        u.src1 = u.insn.dp.f.arith.rn;
        u.src1_status = REG_IS_USED;
      end
    endcase
  end

  // Second source.
  always_comb begin
    case (u.opcode)
      // Store data comes from rt.
      OP_STUR: begin
        u.src2 = u.insn.dp.rd;
        u.src2_status = REG_IS_USED;
      end
      OP_ADDS, OP_SUBS, OP_ORR, OP_ORN, OP_EOR, OP_ANDS,
      OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: begin
        u.src2 = u.insn.dp.f.rrr.rm;
        u.src2_status = REG_IS_USED;
      end
      OP_LDUR, OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP, OP_ADD, OP_SUB,
      OP_B, OP_B_COND, OP_BL: begin
        u.src2 = ZERO_REG;
        u.src2_status = REG_IS_IMM;
      end
      default: begin
        u.src2 = ZERO_REG;
        u.src2_status = REG_IS_UNUSED;
      end
    endcase
  end

  // Immediate. Branch offsets are word counts, scaled to bytes here.
  always_comb begin
    case (u.opcode)
      OP_LDUR, OP_STUR: u.imm = IMM_WIDTH'($signed(u.insn.dp.f.mem.imm9));
      OP_ADD, OP_SUB: u.imm = IMM_WIDTH'(u.insn.dp.f.arith.imm12);
      OP_MOVZ, OP_MOVK: u.imm = IMM_WIDTH'(u.insn.dp.f.mov.hw16);
      OP_ADR: u.imm = IMM_WIDTH'($signed({u.insn.br.f.adr.immhi, u.insn.br.immlo}));
      OP_ADRP: u.imm = IMM_WIDTH'($signed({u.insn.br.f.adr.immhi, u.insn.br.immlo, 12'h000}));
      OP_B, OP_BL: u.imm = IMM_WIDTH'($signed({u.insn.br.f.imm26, 2'b00}));
      OP_B_COND, OP_CBZ, OP_CBNZ: u.imm = IMM_WIDTH'($signed({u.insn.br.f.cb.imm19, 2'b00}));
      default: u.imm = '0;
    endcase
  end

  // Condition code.
  always_comb begin
    case (u.opcode)
      OP_B_COND: u.cond = cond_t'(u.insn.br.f.cb.cond);
      OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: u.cond = cond_t'(u.insn.dp.f.rrr.cond);
      default: u.cond = COND_EQ;
    endcase
  end

  // Later stages use ZERO_REG to skip the writeback path.
  a_unused_dst_zero: assert property (
    @(posedge u.clk) (u.dst_status == REG_IS_UNUSED) |-> (u.dst == ZERO_REG)
  ) else $error("unused destination does not carry the zero register");

endmodule

// File: hw/uop_control.sv
`timescale 1ns/1ps

module uop_control
  import isa_pkg::*, uop_pkg::*;
(
  uop_if.control u
);

  // Only the unscaled loads and stores go to the load/store unit.
  always_comb begin
    if (u.opcode == OP_LDUR || u.opcode == OP_STUR) begin
      u.fu_id = FU_LS;
    end else begin
      u.fu_id = FU_ALU;
    end
  end

  always_comb begin
    case (u.opcode)
      OP_ADD, OP_ADDS: u.fu_op = FU_OP_PLUS;
      OP_SUB, OP_SUBS: u.fu_op = FU_OP_MINUS;
      OP_ORR: u.fu_op = FU_OP_OR;
      OP_ORN: u.fu_op = FU_OP_ORN;
      OP_EOR: u.fu_op = FU_OP_EOR;
      OP_ANDS: u.fu_op = FU_OP_AND;
      OP_MOVZ, OP_MOVK: u.fu_op = FU_OP_MOV;
      OP_CSEL: u.fu_op = FU_OP_CSEL;
      OP_CSINC: u.fu_op = FU_OP_CSINC;
      OP_CSINV: u.fu_op = FU_OP_CSINV;
      OP_CSNEG: u.fu_op = FU_OP_CSNEG;
      OP_LDUR: u.fu_op = FU_OP_LDUR;
      OP_STUR: u.fu_op = FU_OP_STUR;
      OP_ADR, OP_ADRP: u.fu_op = FU_OP_ADRX;
      OP_B_COND: u.fu_op = FU_OP_B_COND;
      // BR, BLR and the rest just forward operand A.
      default: u.fu_op = FU_OP_PASS_A;
    endcase
  end

  // Flag producers and consumers.
  always_comb begin
    u.sets_nzcv = 1'b0;
    u.uses_nzcv = 1'b0;
    case (u.opcode)
      OP_ADDS, OP_SUBS, OP_ANDS: begin
        u.sets_nzcv = 1'b1;
      end
      OP_B_COND, OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: begin
        u.uses_nzcv = 1'b1;
      end
      default: begin
        u.sets_nzcv = 1'b0;
        u.uses_nzcv = 1'b0;
      end
    endcase
  end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import isa_pkg::*, uop_pkg::*;
#(
  parameter int PC_WIDTH = 64
) (
  input logic in_clk,
  input logic in_rst,
  input logic insn_valid,
  input logic [INSN_WIDTH-1:0] insn,
  input logic [PC_WIDTH-1:0] pc,
  output logic dec_valid,
  output logic [PC_WIDTH-1:0] dec_pc,
  output opcode_t opcode,
  output fu_t fu_id,
  output fu_op_t fu_op,
  output logic [GPR_IDX_WIDTH-1:0] src1,
  output reg_status_t src1_status,
  output logic [GPR_IDX_WIDTH-1:0] src2,
  output reg_status_t src2_status,
  output logic [GPR_IDX_WIDTH-1:0] dst,
  output reg_status_t dst_status,
  output logic [IMM_WIDTH-1:0] imm,
  output cond_t cond,
  output logic sets_nzcv,
  output logic uses_nzcv
);

  uop_if #(.PC_WIDTH(PC_WIDTH)) u_if (.clk(in_clk));

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

  // Word and pc hold until the next valid strobe.
  always_ff @(posedge in_clk) begin
    if (insn_valid) begin
      u_if.insn <= insn;
      u_if.pc <= pc;
    end
  end

  opcode_decoder opcode_decoder_i (.u(u_if));
  operand_extractor operand_extractor_i (.u(u_if));
  uop_control uop_control_i (.u(u_if));

  assign dec_pc = u_if.pc;
  assign opcode = u_if.opcode;
  assign fu_id = u_if.fu_id;
  assign fu_op = u_if.fu_op;
  assign src1 = u_if.src1;
  assign src1_status = u_if.src1_status;
  assign src2 = u_if.src2;
  assign src2_status = u_if.src2_status;
  assign dst = u_if.dst;
  assign dst_status = u_if.dst_status;
  assign imm = u_if.imm;
  assign cond = u_if.cond;
  assign sets_nzcv = u_if.sets_nzcv;
  assign uses_nzcv = u_if.uses_nzcv;

  // One result per accepted word, exactly one cycle later.
  a_valid_one_cycle: assert property (
    @(posedge in_clk) disable iff (in_rst) dec_valid == $past(insn_valid && !in_rst)
  ) else $error("dec_valid does not follow insn_valid by one cycle");

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb
  import isa_pkg::*, uop_pkg::*;
;

  localparam int PC_WIDTH = 64;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_KEPT = 28;
  localparam int N_BACK = 300;
  localparam int N_MIX = 600;
  // Every stimulus word takes one clock, plus reset and a few drain cycles.
  localparam int TIMEOUT_NS = (RESET_CYCLES + N_BACK + N_MIX + 8) * CLK_PERIOD + 2000;

  logic clk;
  logic in_rst;
  logic insn_valid;
  logic [INSN_WIDTH-1:0] insn;
  logic [PC_WIDTH-1:0] pc;
  logic dec_valid;
  logic [PC_WIDTH-1:0] dec_pc;
  opcode_t opcode;
  fu_t fu_id;
  fu_op_t fu_op;
  logic [GPR_IDX_WIDTH-1:0] src1;
  reg_status_t src1_status;
  logic [GPR_IDX_WIDTH-1:0] src2;
  reg_status_t src2_status;
  logic [GPR_IDX_WIDTH-1:0] dst;
  reg_status_t dst_status;
  logic [IMM_WIDTH-1:0] imm;
  cond_t cond;
  logic sets_nzcv;
  logic uses_nzcv;

  integer seed = 35197;
  int n_checks;
  int n_errors;

  // Last accepted word, and whether dec_valid should be high at the next check.
  logic exp_valid;
  bit have_word;
  logic [31:0] last_word;
  logic [PC_WIDTH-1:0] last_pc;

  opcode_t exp_op;
  fu_t exp_fu;
  fu_op_t exp_fu_op;
  logic [4:0] exp_src1;
  logic [4:0] exp_src2;
  logic [4:0] exp_dst;
  reg_status_t exp_src1_st;
  reg_status_t exp_src2_st;
  reg_status_t exp_dst_st;
  logic [63:0] exp_imm;
  cond_t exp_cond;
  logic exp_sets;
  logic exp_uses;

  // A64 encodings of the kept instructions, in opcode order. ? marks a free bit.
  string patterns [NUM_KEPT] = '{
    "11111000_010?????_????00??_????????", "11111000_000?????_????00??_????????",
    "11010010_1???????_????????_????????", "11110010_1???????_????????_????????",
    "0??10000_????????_????????_????????", "1??10000_????????_????????_????????",
    "10010001_0???????_????????_????????", "11010001_0???????_????????_????????",
    "10101011_000?????_????????_????????", "11101011_000?????_????????_????????",
    "10101010_000?????_????????_????????", "10101010_001?????_????????_????????",
    "11001010_000?????_????????_????????", "11101010_000?????_????????_????????",
    "10011010_100?????_????00??_????????", "10011010_100?????_????01??_????????",
    "11011010_100?????_????00??_????????", "11011010_100?????_????01??_????????",
    "000101??_????????_????????_????????", "01010100_????????_????????_???0????",
    "100101??_????????_????????_????????", "11010110_00011111_000000??_???00000",
    "11010110_00111111_000000??_???00000", "11010110_01011111_000000??_???00000",
    "10110100_????????_????????_????????", "10110101_????????_????????_????????",
    "11010101_00000011_00100000_00011111", "11010100_010?????_????????_???00000"
  };
  logic [31:0] pat_mask [NUM_KEPT];
  logic [31:0] pat_bits [NUM_KEPT];

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) tb_clock_i (.clk(clk));

  decode_stage #(.PC_WIDTH(PC_WIDTH)) decode_stage_i (
    .in_clk(clk),
    .in_rst(in_rst),
    .insn_valid(insn_valid),
    .insn(insn),
    .pc(pc),
    .dec_valid(dec_valid),
    .dec_pc(dec_pc),
    .opcode(opcode),
    .fu_id(fu_id),
    .fu_op(fu_op),
    .src1(src1),
    .src1_status(src1_status),
    .src2(src2),
    .src2_status(src2_status),
    .dst(dst),
    .dst_status(dst_status),
    .imm(imm),
    .cond(cond),
    .sets_nzcv(sets_nzcv),
    .uses_nzcv(uses_nzcv)
  );

  task automatic load_patterns();
    string p;
    for (int k = 0; k < NUM_KEPT; k++) begin
      p = patterns[k];
      pat_mask[k] = '0;
      pat_bits[k] = '0;
      for (int i = 0; i < p.len(); i++) begin
        if (p[i] != "_") begin
          pat_mask[k] = {pat_mask[k][30:0], p[i] != "?"};
          pat_bits[k] = {pat_bits[k][30:0], p[i] == "1"};
        end
      end
    end
  endtask

  // Reference decode of one word into the exp_* fields.
  task automatic model_decode(input logic [31:0] w);
    opcode_t op;
    op = OP_ERR;
    // Walk down so that the first matching table entry wins.
    for (int k = NUM_KEPT - 1; k >= 0; k--) begin
      if ((w & pat_mask[k]) == pat_bits[k]) begin
        op = opcode_t'(k);
      end
    end
    exp_op = op;
    exp_fu = (op inside {OP_LDUR, OP_STUR}) ? FU_LS : FU_ALU;
    case (op)
      OP_ADD, OP_ADDS: exp_fu_op = FU_OP_PLUS;
      OP_SUB, OP_SUBS: exp_fu_op = FU_OP_MINUS;
      OP_ORR: exp_fu_op = FU_OP_OR;
      OP_ORN: exp_fu_op = FU_OP_ORN;
      OP_EOR: exp_fu_op = FU_OP_EOR;
      OP_ANDS: exp_fu_op = FU_OP_AND;
      OP_MOVZ, OP_MOVK: exp_fu_op = FU_OP_MOV;
      OP_CSEL: exp_fu_op = FU_OP_CSEL;
      OP_CSINC: exp_fu_op = FU_OP_CSINC;
      OP_CSINV: exp_fu_op = FU_OP_CSINV;
      OP_CSNEG: exp_fu_op = FU_OP_CSNEG;
      OP_LDUR: exp_fu_op = FU_OP_LDUR;
      OP_STUR: exp_fu_op = FU_OP_STUR;
      OP_ADR, OP_ADRP: exp_fu_op = FU_OP_ADRX;
      OP_B_COND: exp_fu_op = FU_OP_B_COND;
      default: exp_fu_op = FU_OP_PASS_A;
    endcase

    exp_dst = w[4:0];
    exp_dst_st = REG_IS_USED;
    if (op inside {OP_B, OP_BR, OP_B_COND, OP_CBZ, OP_CBNZ, OP_RET, OP_NOP, OP_HLT, OP_ERR}) begin
      exp_dst = ZERO_REG;
      exp_dst_st = REG_IS_UNUSED;
    end else if (op == OP_STUR) begin
      exp_dst = ZERO_REG;
      exp_dst_st = REG_IS_STUR;
    end else if (op inside {OP_BL, OP_BLR}) begin
      exp_dst = LINK_REG;
    end

    exp_src1 = w[9:5];
    exp_src1_st = REG_IS_USED;
    if (op inside {OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP, OP_B, OP_BL, OP_NOP, OP_HLT, OP_ERR}) begin
      exp_src1 = ZERO_REG;
      exp_src1_st = REG_IS_UNUSED;
    end else if (op == OP_B_COND) begin
      exp_src1 = ZERO_REG;
      exp_src1_st = REG_IS_PC;
    end else if (op inside {OP_CBZ, OP_CBNZ}) begin
      exp_src1 = w[4:0];
    end

    exp_src2 = ZERO_REG;
    exp_src2_st = REG_IS_UNUSED;
    if (op == OP_STUR) begin
      exp_src2 = w[4:0];
      exp_src2_st = REG_IS_USED;
    end else if (op inside {[OP_ADDS:OP_ANDS], [OP_CSEL:OP_CSNEG]}) begin
      exp_src2 = w[20:16];
      exp_src2_st = REG_IS_USED;
    end else if (op inside {[OP_LDUR:OP_SUB], OP_B, OP_B_COND, OP_BL}) begin
      exp_src2_st = REG_IS_IMM;
    end

    // Offsets are two's complement, branch targets count words.
    exp_imm = '0;
    if (op inside {OP_LDUR, OP_STUR}) exp_imm = {{55{w[20]}}, w[20:12]};
    else if (op inside {OP_ADD, OP_SUB}) exp_imm = {52'd0, w[21:10]};
    else if (op inside {OP_MOVZ, OP_MOVK}) exp_imm = {48'd0, w[20:5]};
    else if (op == OP_ADR) exp_imm = {{43{w[23]}}, w[23:5], w[30:29]};
    else if (op == OP_ADRP) exp_imm = {{31{w[23]}}, w[23:5], w[30:29], 12'd0};
    else if (op inside {OP_B, OP_BL}) exp_imm = {{36{w[25]}}, w[25:0], 2'b00};
    else if (op inside {OP_B_COND, OP_CBZ, OP_CBNZ}) exp_imm = {{43{w[23]}}, w[23:5], 2'b00};

    exp_cond = COND_EQ;
    if (op == OP_B_COND) exp_cond = cond_t'(w[3:0]);
    else if (op inside {[OP_CSEL:OP_CSNEG]}) exp_cond = cond_t'(w[15:12]);
    exp_sets = op inside {OP_ADDS, OP_SUBS, OP_ANDS};
    exp_uses = op inside {OP_B_COND, [OP_CSEL:OP_CSNEG]};
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs hold the last accepted word's decode even while dec_valid is low.
  task automatic check_outputs();
    string tag;
    check_value(64'(dec_valid), 64'(exp_valid), "dec_valid");
    if (have_word) begin
      tag = $sformatf("insn %h", last_word);
      model_decode(last_word);
      check_value(64'(dec_pc), 64'(last_pc), {tag, " dec_pc"});
      check_value(64'(opcode), 64'(exp_op), {tag, " opcode"});
      check_value(64'(fu_id), 64'(exp_fu), {tag, " fu_id"});
      check_value(64'(fu_op), 64'(exp_fu_op), {tag, " fu_op"});
      check_value(64'(src1), 64'(exp_src1), {tag, " src1"});
      check_value(64'(src1_status), 64'(exp_src1_st), {tag, " src1_status"});
      check_value(64'(src2), 64'(exp_src2), {tag, " src2"});
      check_value(64'(src2_status), 64'(exp_src2_st), {tag, " src2_status"});
      check_value(64'(dst), 64'(exp_dst), {tag, " dst"});
      check_value(64'(dst_status), 64'(exp_dst_st), {tag, " dst_status"});
      check_value(imm, exp_imm, {tag, " imm"});
      check_value(64'(cond), 64'(exp_cond), {tag, " cond"});
      check_value(64'(sets_nzcv), 64'(exp_sets), {tag, " sets_nzcv"});
      check_value(64'(uses_nzcv), 64'(exp_uses), {tag, " uses_nzcv"});
    end
  endtask

  task automatic report_test(input string name, input int checks0, input int errors0);
    $display("test %s: %0d checks, %0d errors", name, n_checks - checks0, n_errors - errors0);
  endtask

  task automatic run_reset();
    int checks0;
    int errors0;
    checks0 = n_checks;
    errors0 = n_errors;
    // A valid strobe held through reset must not reach dec_valid.
    insn_valid = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_value(64'(dec_valid), 64'd0, "dec_valid during reset");
    end
    in_rst = 1'b0;
    insn_valid = 1'b0;
    @(negedge clk);
    check_value(64'(dec_valid), 64'd0, "dec_valid in first cycle after reset");
    report_test("reset", checks0, errors0);
  endtask

  // Drives count words, with idle gaps and fully random words when asked.
  task automatic run_stream(input string name, input int count, input bit gaps, input bit wild);
    int checks0;
    int errors0;
    logic [31:0] r;
    logic [31:0] w;
    int k;
    checks0 = n_checks;
    errors0 = n_errors;
    for (int n = 0; n < count; n++) begin
      @(negedge clk);
      check_outputs();
      r = $random(seed);
      if (wild && r[4:2] == 3'd0) begin
        w = $random(seed);
      end else begin
        k = int'($unsigned($random(seed)) % NUM_KEPT);
        w = ($random(seed) & ~pat_mask[k]) | pat_bits[k];
      end
      insn = w;
      pc = {$random(seed), $random(seed)};
      insn_valid = !gaps || r[1:0] != 2'd0;
      if (insn_valid) begin
        last_word = w;
        last_pc = pc;
        have_word = 1'b1;
      end
      exp_valid = insn_valid;
    end
    @(negedge clk);
    check_outputs();
    insn_valid = 1'b0;
    exp_valid = 1'b0;
    report_test(name, checks0, errors0);
  endtask

  initial begin
    in_rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    pc = '0;
    exp_valid = 1'b0;
    have_word = 1'b0;
    n_checks = 0;
    n_errors = 0;
    load_patterns();
    run_reset();
    run_stream("back_to_back", N_BACK, 1'b0, 1'b0);
    run_stream("random_mix", N_MIX, 1'b1, 1'b1);
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: sources.f
hw/isa_pkg.sv
hw/uop_pkg.sv
hw/uop_if.sv
hw/opcode_decoder.sv
hw/operand_extractor.sv
hw/uop_control.sv
hw/decode_stage.sv
test/tb_clock.sv
test/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= decode_stage_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
